//--- io_subsystem.f
verilog/io_pkg.sv
verilog/io_port_decoder.sv
verilog/led_register.sv
verilog/interval_timer.sv
verilog/irq_controller.sv
verilog/io_subsystem.sv
tests/io_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the I/O subsystem testbench with Verilator and run it.
# The exit status of the simulation is the test result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f io_subsystem.f \
    --top-module io_subsystem_tb \
    -o io_subsystem_sim

./obj_dir/io_subsystem_sim

//--- tests/io_subsystem_tb.sv
// Testbench for the I/O port subsystem, acting as the CPU data master.
// One access at a time; every ack wait and the timer wait have a timeout.
// The live timer count is only checked for direction and for stability.
`timescale 1ns/1ps

module io_subsystem_tb;

    import io_pkg::*;

    localparam int NUM_LEDS = 8;
    localparam int TIMER_PRESCALE = 4;
    localparam logic [15:0] LED_MASK = 16'((32'd1 << NUM_LEDS) - 1);

    logic                clk;
    logic                rst_n;
    io_req_t             req;
    io_rsp_t             rsp;
    logic [NUM_LEDS-1:0] leds;
    logic                intr;
    logic [2:0]          irq_vector;

    // Reference model state
    logic [15:0] ref_leds;
    logic [15:0] ref_reload;
    logic [15:0] ref_count;
    logic [7:0]  ref_mask;
    logic [7:0]  ref_pending;
    logic [7:0]  ref_test;
    logic        ref_timer_en;

    integer      seed;
    integer      rnd;
    logic [15:0] data;
    logic [15:0] prev;
    logic [15:0] cur;
    logic [15:0] unmapped [5];
    int          n;

    io_subsystem #(.NUM_LEDS(NUM_LEDS), .TIMER_PRESCALE(TIMER_PRESCALE)) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .rsp        (rsp),
        .leds       (leds),
        .intr       (intr),
        .irq_vector (irq_vector)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string msg);
        $display("timeout at %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "stopped on timeout");
    endtask

    // Expected read data for a port, word address only
    function automatic logic [15:0] ref_read(input logic [15:0] addr);
        logic [15:1] word;
        logic [15:0] val;
        word = addr[15:1];
        val  = 16'h0000;
        if (word == PORT_LEDS[15:1])
            val = ref_leds & LED_MASK;
        else if (word == PORT_IRQ[15:1])
            val = {ref_pending, ref_mask};
        else if (word == PORT_IRQ_TEST[15:1])
            val = {8'h00, ref_test[7:1], 1'b0};
        else if (word == PORT_TIMER_CTRL[15:1])
            val = {15'h0000, ref_timer_en};
        else if (word == PORT_TIMER_COUNT[15:1])
            val = ref_count;  // Valid while stopped
        return val;
    endfunction

    function automatic logic [2:0] ref_vector(input logic [7:0] active);
        logic [2:0] vec;
        logic       found;
        vec   = 3'd0;
        found = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (active[i] && !found) begin
                vec   = 3'(i);
                found = 1'b1;
            end
        end
        return vec;
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [15:0] wdata,
                               input logic [1:0] bs);
        logic [15:1] word;
        word = addr[15:1];
        if (word == PORT_LEDS[15:1]) begin
            if (bs[0]) ref_leds[7:0] = wdata[7:0];
            if (bs[1]) ref_leds[15:8] = wdata[15:8];
            ref_leds = ref_leds & LED_MASK;
        end else if (word == PORT_IRQ[15:1]) begin
            if (bs[0]) ref_mask = wdata[7:0];
            if (bs[1]) ref_pending = ref_pending & ~wdata[15:8];
        end else if (word == PORT_IRQ_TEST[15:1]) begin
            if (bs[0]) ref_test = {wdata[7:1], 1'b0};  // Line 0 is hardware only
        end else if (word == PORT_TIMER_CTRL[15:1]) begin
            if (bs[0]) ref_timer_en = wdata[0];
        end else if (word == PORT_TIMER_COUNT[15:1]) begin
            if (bs[0]) ref_reload[7:0] = wdata[7:0];
            if (bs[1]) ref_reload[15:8] = wdata[15:8];
            ref_count = ref_reload;
        end
        ref_pending = ref_pending | ref_test;  // Active test bits latch again
    endtask

    task automatic bus_cycle(input logic wr, input logic [15:0] addr,
                             input logic [15:0] wdata, input logic [1:0] bs,
                             output logic [15:0] rdata);
        int waits;
        @(posedge clk);
        req.access  <= 1'b1;
        req.wr_en   <= wr;
        req.addr    <= addr[15:1];
        req.bytesel <= bs;
        req.wdata   <= wdata;
        waits = 0;
        @(posedge clk);
        while (!rsp.ack) begin
            waits++;
            if (waits > 20)
                report_timeout("no ack from the port bus");
            @(posedge clk);
        end
        rdata = rsp.rdata;
        req.access <= 1'b0;
        check_value(16'(waits), 16'd1, "ack latency");
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [15:0] wdata,
                            input logic [1:0] bs);
        logic [15:0] unused_rdata;
        bus_cycle(1'b1, addr, wdata, bs, unused_rdata);
        model_write(addr, wdata, bs);
    endtask

    task automatic io_read(input logic [15:0] addr, output logic [15:0] rdata);
        bus_cycle(1'b0, addr, 16'h0000, 2'b11, rdata);
    endtask

    task automatic read_and_check(input logic [15:0] addr, input string msg);
        logic [15:0] rdata;
        io_read(addr, rdata);
        check_value(rdata, ref_read(addr), msg);
    endtask

    task automatic check_irq_outputs(input string msg);
        logic [7:0] active;
        active = ref_pending & ~ref_mask;
        check_value({15'h0000, intr}, {15'h0000, |active}, {msg, " intr"});
        check_value({13'h0000, irq_vector}, {13'h0000, ref_vector(active)}, {msg, " vector"});
    endtask

    initial begin
        seed         = 32'h3c7e;
        rst_n        <= 1'b0;
        req          <= '0;
        ref_leds     = 16'h0000;
        ref_reload   = 16'h0000;
        ref_count    = 16'h0000;
        ref_mask     = 8'hff;
        ref_pending  = 8'h00;
        ref_test     = 8'h00;
        ref_timer_en = 1'b0;
        unmapped     = '{16'h1234, 16'h0044, 16'h0022, 16'hfff0, 16'h8000};
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        check_value(16'(leds), 16'h0000, "leds after reset");
        read_and_check(PORT_LEDS, "led read after reset");
        read_and_check(PORT_IRQ, "mask after reset");
        read_and_check(PORT_TIMER_COUNT, "timer count after reset");
        check_irq_outputs("after reset");

        // LED byte lanes, last pass through the odd address
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            io_write((i == 11) ? 16'hffff : PORT_LEDS, rnd[15:0], 2'(i));
            read_and_check(PORT_LEDS, "led read back");
            check_value(16'(leds), ref_leds & LED_MASK, "leds output");
        end

        // Unmapped ports
        foreach (unmapped[i]) begin
            rnd = $random(seed);
            io_write(unmapped[i], rnd[15:0], 2'b11);
            read_and_check(unmapped[i], "unmapped read");
        end
        read_and_check(PORT_LEDS, "leds after unmapped writes");
        read_and_check(PORT_IRQ, "irq after unmapped writes");
        read_and_check(PORT_IRQ_TEST, "test bits after unmapped writes");
        read_and_check(PORT_TIMER_CTRL, "timer ctrl after unmapped writes");
        read_and_check(PORT_TIMER_COUNT, "timer count after unmapped writes");

        // Interrupt controller with software requests
        io_write(PORT_IRQ_TEST, 16'h00a7, 2'b01);
        read_and_check(PORT_IRQ_TEST, "test bits");
        io_write(PORT_IRQ, 16'h00db, 2'b01);     // Lines 2 and 5 open
        read_and_check(PORT_IRQ, "pending and mask");
        check_irq_outputs("unmasked test irqs");
        io_write(PORT_IRQ_TEST, 16'h00a2, 2'b01);
        io_write(PORT_IRQ, 16'h0400, 2'b10);
        read_and_check(PORT_IRQ, "clear pending 2");
        check_irq_outputs("after clear 2");
        io_write(PORT_IRQ, 16'h2000, 2'b10);     // Test bit 5 still set
        read_and_check(PORT_IRQ, "relatch pending 5");
        check_irq_outputs("after relatch 5");
        io_write(PORT_IRQ, 16'h00d9, 2'b01);
        read_and_check(PORT_IRQ, "line 1 opened");
        check_irq_outputs("line 1 opened");
        io_write(PORT_IRQ_TEST, 16'h0000, 2'b01);
        io_write(PORT_IRQ, 16'hffff, 2'b11);
        read_and_check(PORT_IRQ, "irq cleanup");
        check_irq_outputs("irq cleanup");

        // Interval timer
        io_write(PORT_TIMER_COUNT, 16'd12, 2'b11);
        read_and_check(PORT_TIMER_COUNT, "count after load");
        io_write(PORT_TIMER_CTRL, 16'h0001, 2'b01);
        read_and_check(PORT_TIMER_CTRL, "timer enabled");
        io_read(PORT_TIMER_COUNT, prev);
        cur = prev;
        for (int i = 0; i < 5; i++) begin
            io_read(PORT_TIMER_COUNT, cur);
            check_value({15'h0000, cur <= prev}, 16'h0001, "timer count increased");
            prev = cur;
        end
        check_value({15'h0000, cur < 16'd12}, 16'h0001, "timer count not running");
        n    = 0;
        data = 16'h0000;
        while (!data[8]) begin
            n++;
            if (n > 40)
                report_timeout("timer interrupt never became pending");
            io_read(PORT_IRQ, data);
        end
        ref_pending[0] = 1'b1;
        check_value(data, ref_read(PORT_IRQ), "pending after timer");
        io_write(PORT_IRQ, 16'h00fe, 2'b01);
        read_and_check(PORT_IRQ, "timer line unmasked");
        check_irq_outputs("timer irq");
        io_write(PORT_TIMER_CTRL, 16'h0000, 2'b01);
        read_and_check(PORT_TIMER_CTRL, "timer disabled");
        io_read(PORT_TIMER_COUNT, prev);
        for (int i = 0; i < 4; i++) begin
            io_read(PORT_TIMER_COUNT, cur);
            check_value(cur, prev, "count moved while disabled");
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- verilog/interval_timer.sv
// Programmable interval timer.
// COUNT port loads reload value and counter, reads give the live counter.
// CTRL port bit 0 enables counting; the prescaler restarts on enable
// and on every count write. TIMER_PRESCALE must be at least 2 so that
// the interrupt pulse stays one cycle wide. A reload of 0 never fires.
`timescale 1ns/1ps

module interval_timer #(
    parameter int TIMER_PRESCALE = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  io_pkg::io_req_t req,
    input  logic            cs,
    output io_pkg::io_rsp_t rsp,
    output logic            timer_intr
);

    import io_pkg::*;

    localparam int PW = $clog2(TIMER_PRESCALE);

    logic          hit;
    logic          sel_ctrl;
    logic          count_wr;
    logic          ctrl_wr;
    logic          tick;
    logic          enable;
    logic [PW-1:0] presc;
    logic [15:0]   count;
    logic [15:0]   reload;
    logic [15:0]   load_val;
    logic [15:0]   read_val;

    assign hit      = cs && !rsp.ack;
    assign sel_ctrl = (req.addr == PORT_TIMER_CTRL[15:1]);
    assign count_wr = hit && req.wr_en && !sel_ctrl;
    assign ctrl_wr  = hit && req.wr_en && sel_ctrl && req.bytesel[0];
    assign load_val = merge_bytes(reload, req.wdata, req.bytesel);
    assign read_val = sel_ctrl ? {15'h0000, enable} : count;

    // One tick every TIMER_PRESCALE clocks while enabled
    assign tick = enable && (presc == PW'(TIMER_PRESCALE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp        <= '0;
            enable     <= 1'b0;
            presc      <= '0;
            count      <= 16'h0000;
            reload     <= 16'h0000;
            timer_intr <= 1'b0;
        end else begin
            rsp.ack    <= hit;
            rsp.rdata  <= (hit && !req.wr_en) ? read_val : 16'h0000;
            timer_intr <= 1'b0;

            if (count_wr)
                reload <= load_val;

            if (ctrl_wr)
                enable <= req.wdata[0];

            if (!enable || count_wr || tick)
                presc <= '0;
            else
                presc <= presc + 1'b1;

            if (count_wr) begin
                count <= load_val;  // Bus write beats the decrement
            end else if (tick && count != 16'h0000) begin
                if (count == 16'h0001) begin
                    count      <= reload;
                    timer_intr <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    a_intr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        timer_intr |=> !timer_intr);

endmodule

//--- verilog/io_pkg.sv
// Shared types for the 16-bit I/O port bus.
// Port addresses are byte addresses; the bus carries word addresses
// in bits 15:1, so every port is matched on bits 15:1 only.
// rdata of a response must be zero when ack is low so that the
// responses of all peripherals can be ORed together.
package io_pkg;

    typedef struct packed {
        logic        access;
        logic        wr_en;
        logic [15:1] addr;    // Word address
        logic [1:0]  bytesel;
        logic [15:0] wdata;
    } io_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] rdata;
    } io_rsp_t;

    typedef enum logic [2:0] {
        TGT_NONE,
        TGT_LEDS,
        TGT_TIMER,
        TGT_IRQ_MASK,
        TGT_IRQ_TEST,
        TGT_DEFAULT
    } io_target_e;

    localparam logic [15:0] PORT_LEDS        = 16'hfffe;
    localparam logic [15:0] PORT_IRQ_TEST    = 16'hfff6;
    localparam logic [15:0] PORT_TIMER_COUNT = 16'h0040;
    localparam logic [15:0] PORT_TIMER_CTRL  = 16'h0042;
    localparam logic [15:0] PORT_IRQ         = 16'h0020;

    localparam int NUM_IRQS = 8;

    // Byte-lane write merge used by the word registers
    function automatic logic [15:0] merge_bytes(input logic [15:0] old_val,
                                                input logic [15:0] new_val,
                                                input logic [1:0]  bytesel);
        return {bytesel[1] ? new_val[15:8] : old_val[15:8],
                bytesel[0] ? new_val[7:0] : old_val[7:0]};
    endfunction

endpackage

//--- verilog/io_port_decoder.sv
// Port address decoder for the I/O bus.
// Chip selects are combinational from the request and qualified by access.
// Any unmapped port is acked one cycle later with zero read data,
// and writes to it are dropped.
`timescale 1ns/1ps

module io_port_decoder (
    input  logic           clk,
    input  logic           rst_n,
    input  io_pkg::io_req_t req,
    output logic           cs_leds,
    output logic           cs_timer,
    output logic           cs_irq,
    input  io_pkg::io_rsp_t rsp_leds,
    input  io_pkg::io_rsp_t rsp_timer,
    input  io_pkg::io_rsp_t rsp_irq,
    output io_pkg::io_rsp_t rsp
);

    import io_pkg::*;

    io_target_e target;
    io_rsp_t    rsp_dflt;
    logic       dflt_ack;

    always_comb begin
        target = TGT_NONE;
        if (req.access) begin
            case (req.addr)
                PORT_LEDS[15:1]:        target = TGT_LEDS;
                PORT_TIMER_COUNT[15:1],
                PORT_TIMER_CTRL[15:1]:  target = TGT_TIMER;
                PORT_IRQ[15:1]:         target = TGT_IRQ_MASK;
                PORT_IRQ_TEST[15:1]:    target = TGT_IRQ_TEST;
                default:                target = TGT_DEFAULT;
            endcase
        end
    end

    assign cs_leds  = (target == TGT_LEDS);
    assign cs_timer = (target == TGT_TIMER);
    // Controller tells its two ports apart itself
    assign cs_irq   = (target == TGT_IRQ_MASK) || (target == TGT_IRQ_TEST);

    // Default responder, same one-cycle latency as the peripherals
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dflt_ack <= 1'b0;
        end else begin
            dflt_ack <= (target == TGT_DEFAULT) && !dflt_ack;
        end
    end

    assign rsp_dflt.ack   = dflt_ack;
    assign rsp_dflt.rdata = '0;

    assign rsp = rsp_leds | rsp_timer | rsp_irq | rsp_dflt;

    a_onehot_cs: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({cs_leds, cs_timer, cs_irq}));

endmodule

//--- verilog/io_subsystem.sv
// I/O port subsystem: decoder, LED register, interval timer and
// interrupt controller on one shared request bus.
// Every port acks exactly one cycle after the access is seen.
// Only the timer drives a hardware interrupt line (line 0).
`timescale 1ns/1ps

module io_subsystem #(
    parameter int NUM_LEDS       = 8,
    parameter int TIMER_PRESCALE = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  io_pkg::io_req_t     req,
    output io_pkg::io_rsp_t     rsp,
    output logic [NUM_LEDS-1:0] leds,
    output logic                intr,
    output logic [2:0]          irq_vector
);

    import io_pkg::*;

    logic                cs_leds;
    logic                cs_timer;
    logic                cs_irq;
    io_rsp_t             rsp_leds;
    io_rsp_t             rsp_timer;
    io_rsp_t             rsp_irq;
    logic                timer_intr;
    logic [NUM_IRQS-1:0] irq_lines;

    assign irq_lines = {{(NUM_IRQS - 1){1'b0}}, timer_intr};

    io_port_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .cs_leds   (cs_leds),
        .cs_timer  (cs_timer),
        .cs_irq    (cs_irq),
        .rsp_leds  (rsp_leds),
        .rsp_timer (rsp_timer),
        .rsp_irq   (rsp_irq),
        .rsp       (rsp)
    );

    led_register #(.NUM_LEDS(NUM_LEDS)) u_leds (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .cs    (cs_leds),
        .rsp   (rsp_leds),
        .leds  (leds)
    );

    interval_timer #(.TIMER_PRESCALE(TIMER_PRESCALE)) u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .cs         (cs_timer),
        .rsp        (rsp_timer),
        .timer_intr (timer_intr)
    );

    irq_controller u_irq (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .cs         (cs_irq),
        .rsp        (rsp_irq),
        .irq_lines  (irq_lines),
        .intr       (intr),
        .irq_vector (irq_vector)
    );

endmodule

//--- verilog/irq_controller.sv
// Interrupt controller with latched pending bits.
// PORT_IRQ: read {pending, mask}; low byte write sets the mask,
// high byte write clears the pending bits written as 1.
// PORT_IRQ_TEST: software interrupts on lines 7:1, line 0 is hardware only.
// A request that is still active re-latches its pending bit at once.
// Sized for NUM_IRQS == 8 so both registers fit one byte lane.
`timescale 1ns/1ps

module irq_controller (
    input  logic                        clk,
    input  logic                        rst_n,
    input  io_pkg::io_req_t             req,
    input  logic                        cs,
    output io_pkg::io_rsp_t             rsp,
    input  logic [io_pkg::NUM_IRQS-1:0] irq_lines,
    output logic                        intr,
    output logic [2:0]                  irq_vector
);

    import io_pkg::*;

    logic                hit;
    logic                sel_test;
    logic [NUM_IRQS-1:0] mask;
    logic [NUM_IRQS-1:0] pending;
    logic [NUM_IRQS-1:1] test;
    logic [NUM_IRQS-1:0] set_req;
    logic [NUM_IRQS-1:0] clr_req;
    logic [NUM_IRQS-1:0] active;
    logic [15:0]         read_val;

    assign hit      = cs && !rsp.ack;
    assign sel_test = (req.addr == PORT_IRQ_TEST[15:1]);

    assign set_req = irq_lines | {test, 1'b0};
    assign clr_req = (hit && req.wr_en && !sel_test && req.bytesel[1])
                     ? req.wdata[15:8] : '0;

    assign read_val = sel_test ? {8'h00, test, 1'b0} : {pending, mask};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp     <= '0;
            mask    <= '1;  // All lines masked out of reset
            pending <= '0;
            test    <= '0;
        end else begin
            rsp.ack   <= hit;
            rsp.rdata <= (hit && !req.wr_en) ? read_val : 16'h0000;

            // Set wins over a clear in the same cycle
            pending <= (pending & ~clr_req) | set_req;

            if (hit && req.wr_en && req.bytesel[0]) begin
                if (sel_test)
                    test <= req.wdata[NUM_IRQS-1:1];
                else
                    mask <= req.wdata[NUM_IRQS-1:0];
            end
        end
    end

    assign active = pending & ~mask;
    assign intr   = |active;

    // Lowest numbered unmasked line has priority
    always_comb begin
        irq_vector = 3'd0;
        for (int i = NUM_IRQS - 1; i >= 0; i--) begin
            if (active[i])
                irq_vector = 3'(i);
        end
    end

    a_vector_valid: assert property (@(posedge clk) disable iff (!rst_n)
        intr |-> pending[irq_vector] && !mask[irq_vector]);

endmodule

//--- verilog/led_register.sv
// LED output register on a single word port.
// NUM_LEDS must be between 1 and 16; bits above it are dropped on write
// and read back as zero.
`timescale 1ns/1ps

module led_register #(
    parameter int NUM_LEDS = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  io_pkg::io_req_t     req,
    input  logic                cs,
    output io_pkg::io_rsp_t     rsp,
    output logic [NUM_LEDS-1:0] leds
);

    import io_pkg::*;

    logic        hit;  // First cycle of a selected access
    logic [15:0] led_word;

    assign hit      = cs && !rsp.ack;
    assign led_word = 16'(leds);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
            rsp  <= '0;
        end else begin
            rsp.ack   <= hit;
            rsp.rdata <= (hit && !req.wr_en) ? led_word : 16'h0000;
            if (hit && req.wr_en)
                leds <= NUM_LEDS'(merge_bytes(led_word, req.wdata, req.bytesel));
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.ack |=> !rsp.ack);

endmodule
